//--- build.f
+incdir+src
src/mipsIsaPkg.sv
src/mipsCtrlPkg.sv
src/mipsIfaces.sv
src/instrDecoder.sv
src/regFile.sv
src/aluUnit.sv
src/pcUnit.sv
src/mipsCore.sv
tests/tbClock.sv
tests/mipsTb.sv

//--- run.sh
#!/usr/bin/env bash
# build the MIPS core testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module mipsTb \
  -f build.f \
  -o mipsSim

# exit status is nonzero on a failing run
./obj_dir/mipsSim

//--- tests/mipsTb.sv
/*
 * testbench for the single-cycle MIPS core
 * directed programs, instruction ROM and data RAM models,
 * a reference register model and a watchdog
 */

`timescale 1ns/1ps

`include "mips_defines.svh"

module mipsTb;

  localparam int NUM_TESTS  = 6;
  localparam int CLK_PERIOD = 20;
  localparam int ROM_WORDS  = 64;
  localparam int DMEM_WORDS = 1 << `DMEM_ADDR_BITS;
  // unknown opcode that pads the ROM
  localparam logic [31:0] FILLER = {6'h3f, 26'h0};

  logic                       clk;
  logic                       rst;
  logic [`XLEN-1:0]           instrAddr;
  logic [`XLEN-1:0]           instr;
  logic [`DMEM_ADDR_BITS-1:0] dmemAddr;
  logic [`XLEN-1:0]           dmemWdata;
  logic                       dmemWen;
  logic [`XLEN-1:0]           dmemRdata;
  logic                       rfWrite;
  mipsIsaPkg::regAddrT        rfWriteAddr;
  logic [`XLEN-1:0]           rfWriteData;

  logic [`XLEN-1:0] rom       [ROM_WORDS];
  logic [`XLEN-1:0] ram       [DMEM_WORDS];
  // data image copied into the RAM while in reset
  logic [`XLEN-1:0] preload   [DMEM_WORDS];
  // reference state
  logic [`XLEN-1:0] modelRegs [`REG_COUNT];
  logic [`XLEN-1:0] modelMem  [DMEM_WORDS];
  logic [`XLEN-1:0] modelPc;
  logic [31:0]      lfsr;

  tbClock #(.PERIOD_NS(CLK_PERIOD)) uClock (.clk(clk));

  mipsCore dut (
    .clk         (clk),
    .rst         (rst),
    .instrAddr   (instrAddr),
    .instr       (instr),
    .dmemAddr    (dmemAddr),
    .dmemWdata   (dmemWdata),
    .dmemWen     (dmemWen),
    .dmemRdata   (dmemRdata),
    .rfWrite     (rfWrite),
    .rfWriteAddr (rfWriteAddr),
    .rfWriteData (rfWriteData)
  );

  // ============================================================
  // memory models with same-cycle reads
  // ============================================================
  assign instr     = rom[instrAddr[7:2]];
  assign dmemRdata = ram[dmemAddr];

  always @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i < DMEM_WORDS; i++) begin
        ram[i] <= preload[i];
      end
    end else if (!dmemWen) begin
      ram[dmemAddr] <= dmemWdata;
    end
  end

  // taps 32 22 2 1
  function automatic logic lfsrBit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  // one LFSR step per bit
  function automatic logic [31:0] randomWord();
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      w = {w[30:0], lfsrBit()};
    end
    return w;
  endfunction

  function automatic logic [31:0] encodeR(input int rs, input int rt, input int rd,
                                          input logic [5:0] fn);
    return {6'b000000, 5'(rs), 5'(rt), 5'(rd), 5'b00000, fn};
  endfunction

  function automatic logic [31:0] encodeI(input logic [5:0] op, input int rs, input int rt,
                                          input logic [15:0] imm);
    return {op, 5'(rs), 5'(rt), imm};
  endfunction

  function automatic logic [31:0] encodeJ(input logic [5:0] op, input logic [25:0] target);
    return {op, target};
  endfunction

  task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
    if (actual !== expected) begin
      $display("MISMATCH at time %0t: %s is %h, expected %h", $time, what, actual, expected);
      $display("Some tests failed");
      $fatal(1, "check failed");
    end
  endtask

  // ============================================================
  // reset sequencing
  // ============================================================
  task automatic startTest();
    @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    for (int i = 0; i < ROM_WORDS; i++) begin
      rom[i] = FILLER;
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
      preload[i] = randomWord();
    end
  endtask

  task automatic releaseReset();
    repeat (16) @(posedge clk);
    rst <= 1'b1;
    modelPc = `RESET_PC;
    for (int i = 0; i < `REG_COUNT; i++) begin
      modelRegs[i] = '0;
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
      modelMem[i] = preload[i];
    end
  endtask

  // one instruction per cycle checked mid-cycle against the ISA rules
  task automatic runProgram(input int cycles);
    logic [31:0] iw;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] immExt;
    logic [31:0] ea;
    logic [31:0] pc4;
    logic [31:0] nextPc;
    logic [31:0] wrData;
    logic [4:0]  wrAddr;
    logic        wrEn;
    logic        memWr;
    for (int n = 0; n < cycles; n++) begin
      @(negedge clk);
      iw     = rom[modelPc[7:2]];
      a      = modelRegs[iw[25:21]];
      b      = modelRegs[iw[20:16]];
      immExt = {{16{iw[15]}}, iw[15:0]};
      ea     = a + immExt;
      pc4    = modelPc + 32'd4;
      nextPc = pc4;
      wrEn   = 1'b0;
      wrAddr = iw[15:11];
      wrData = '0;
      memWr  = 1'b0;
      case (iw[31:26])
        mipsIsaPkg::OP_RTYPE: begin
          wrEn = 1'b1;
          case (iw[5:0])
            mipsIsaPkg::FN_ADD: wrData = a + b;
            mipsIsaPkg::FN_SUB: wrData = a - b;
            mipsIsaPkg::FN_AND: wrData = a & b;
            mipsIsaPkg::FN_OR:  wrData = a | b;
            // unsigned compare
            mipsIsaPkg::FN_SLT: wrData = (a < b) ? 32'd1 : 32'd0;
            default:            wrEn = 1'b0;
          endcase
        end
        mipsIsaPkg::OP_LW: begin
          wrEn   = 1'b1;
          wrAddr = iw[20:16];
          wrData = modelMem[ea[8:2]];
        end
        mipsIsaPkg::OP_SW: memWr = 1'b1;
        mipsIsaPkg::OP_BEQ: begin
          if (a == b) begin
            nextPc = pc4 + {immExt[29:0], 2'b00};
          end
        end
        mipsIsaPkg::OP_J: nextPc = {pc4[31:28], iw[25:0], 2'b00};
        mipsIsaPkg::OP_JAL: begin
          nextPc = {pc4[31:28], iw[25:0], 2'b00};
          wrEn   = 1'b1;
          wrAddr = 5'd31;
          wrData = pc4;
        end
        // anything else is a nop
        default: ;
      endcase
      checkValue(instrAddr, modelPc, "instrAddr");
      checkValue(32'(rfWrite), 32'(wrEn), "rfWrite");
      if (wrEn) begin
        checkValue(32'(rfWriteAddr), 32'(wrAddr), "rfWriteAddr");
        checkValue(rfWriteData, wrData, "rfWriteData");
      end
      checkValue(32'(dmemWen), 32'(!memWr), "dmemWen");
      if (memWr) begin
        checkValue(32'(dmemAddr), 32'(ea[8:2]), "dmemAddr");
        checkValue(dmemWdata, b, "dmemWdata");
      end
      if (wrEn && (wrAddr != 5'd0)) begin
        modelRegs[wrAddr] = wrData;
      end
      if (memWr) begin
        modelMem[ea[8:2]] = b;
      end
      modelPc = nextPc;
    end
  endtask

  task automatic compareMemory();
    @(negedge clk);
    for (int i = 0; i < DMEM_WORDS; i++) begin
      checkValue(ram[i], modelMem[i], $sformatf("data memory word %0d", i));
    end
  endtask

  // ============================================================
  // directed tests
  // ============================================================
  task automatic testStraightLine();
    startTest();
    rom[0] = encodeI(mipsIsaPkg::OP_LW, 0, 1, 16'h0000);
    rom[1] = encodeI(mipsIsaPkg::OP_LW, 0, 2, 16'h0004);
    rom[2] = encodeR(1, 2, 3, mipsIsaPkg::FN_ADD);
    rom[3] = encodeR(3, 3, 4, mipsIsaPkg::FN_ADD);
    releaseReset();
    runProgram(8);
    compareMemory();
    // eight words past address 0
    checkValue(instrAddr, 32'd32, "pc after straight-line code");
  endtask

  task automatic testAluOps();
    startTest();
    rom[0] = encodeI(mipsIsaPkg::OP_LW, 0, 1, 16'h0000);
    rom[1] = encodeI(mipsIsaPkg::OP_LW, 0, 2, 16'h0004);
    rom[2] = encodeI(mipsIsaPkg::OP_LW, 0, 3, 16'h0008);
    rom[3] = encodeR(1, 2, 4, mipsIsaPkg::FN_ADD);
    rom[4] = encodeR(1, 2, 5, mipsIsaPkg::FN_SUB);
    rom[5] = encodeR(1, 3, 6, mipsIsaPkg::FN_AND);
    rom[6] = encodeR(2, 3, 7, mipsIsaPkg::FN_OR);
    rom[7] = encodeR(1, 2, 8, mipsIsaPkg::FN_SLT);
    rom[8] = encodeR(2, 1, 9, mipsIsaPkg::FN_SLT);
    releaseReset();
    runProgram(9);
    compareMemory();
  endtask

  task automatic testStoreLoad();
    startTest();
    // base pointer 0x20 in word 1
    preload[1] = 32'h0000_0020;
    rom[0] = encodeI(mipsIsaPkg::OP_LW, 0, 1, 16'h000c);
    rom[1] = encodeI(mipsIsaPkg::OP_LW, 0, 2, 16'h0004);
    rom[2] = encodeI(mipsIsaPkg::OP_SW, 2, 1, 16'h0008);
    rom[3] = encodeI(mipsIsaPkg::OP_LW, 2, 3, 16'h0008);
    rom[4] = encodeI(mipsIsaPkg::OP_SW, 2, 1, 16'hfffc);
    rom[5] = encodeI(mipsIsaPkg::OP_LW, 0, 4, 16'h001c);
    // top word of the memory
    rom[6] = encodeI(mipsIsaPkg::OP_SW, 0, 2, 16'h01fc);
    rom[7] = encodeI(mipsIsaPkg::OP_LW, 0, 5, 16'h01fc);
    releaseReset();
    runProgram(8);
    compareMemory();
    checkValue(ram[10], preload[3], "word stored at 0x28");
  endtask

  task automatic testBranch();
    startTest();
    if (preload[0] == preload[1]) begin
      preload[1] = ~preload[0];
    end
    rom[0] = encodeI(mipsIsaPkg::OP_LW, 0, 1, 16'h0000);
    rom[1] = encodeI(mipsIsaPkg::OP_LW, 0, 2, 16'h0004);
    rom[2] = encodeI(mipsIsaPkg::OP_LW, 0, 3, 16'h0000);
    // taken and skips two words
    rom[3] = encodeI(mipsIsaPkg::OP_BEQ, 1, 3, 16'h0002);
    rom[4] = encodeR(1, 2, 4, mipsIsaPkg::FN_ADD);
    rom[5] = encodeR(1, 2, 5, mipsIsaPkg::FN_ADD);
    // not taken
    rom[6] = encodeI(mipsIsaPkg::OP_BEQ, 1, 2, 16'h0001);
    rom[7] = encodeR(1, 2, 6, mipsIsaPkg::FN_SUB);
    // backward to address 0
    rom[8] = encodeI(mipsIsaPkg::OP_BEQ, 0, 0, 16'hfff7);
    releaseReset();
    runProgram(12);
    compareMemory();
  endtask

  task automatic testJump();
    startTest();
    rom[0]  = encodeJ(mipsIsaPkg::OP_J, 26'd4);
    rom[1]  = encodeR(1, 1, 7, mipsIsaPkg::FN_ADD);
    rom[4]  = encodeJ(mipsIsaPkg::OP_JAL, 26'd10);
    rom[10] = encodeR(31, 0, 1, mipsIsaPkg::FN_ADD);
    rom[11] = encodeJ(mipsIsaPkg::OP_J, 26'd0);
    releaseReset();
    runProgram(5);
    compareMemory();
    // back round the loop with j 4 taken again
    checkValue(instrAddr, 32'h10, "pc after jump loop");
  endtask

  task automatic testZeroUnknown();
    logic [31:0] w;
    startTest();
    rom[0] = encodeI(mipsIsaPkg::OP_LW, 0, 0, 16'h0000);
    rom[1] = encodeR(0, 0, 1, mipsIsaPkg::FN_ADD);
    w = randomWord();
    rom[2] = {6'h3f, w[25:0]};
    // unsupported funct under R-type
    rom[3] = encodeR(1, 2, 5, 6'b000111);
    w = randomWord();
    // sb opcode is outside the subset
    rom[4] = {6'b101000, w[25:0]};
    rom[5] = encodeI(6'b001000, 0, 6, 16'h1234);
    rom[6] = encodeI(mipsIsaPkg::OP_LW, 0, 3, 16'h0000);
    rom[7] = encodeR(3, 0, 4, mipsIsaPkg::FN_ADD);
    releaseReset();
    runProgram(8);
    compareMemory();
  endtask

  // ============================================================
  // sequence and watchdog
  // ============================================================
  initial begin
    lfsr = 32'hfd0b;
    rst <= 1'b0;
    testStraightLine();
    testAluOps();
    testStoreLoad();
    testBranch();
    testJump();
    testZeroUnknown();
    $display("All tests passed");
    $finish;
  end

  initial begin
    #(NUM_TESTS * (16 + 64) * CLK_PERIOD);
    $display("watchdog expired: the tests did not finish in time");
    $display("Some tests failed");
    $fatal(1, "simulation timed out");
  end

endmodule

//--- tests/tbClock.sv
/*
 * testbench clock source
 * free-running clock with a fixed period
 */

`timescale 1ns/1ps

module tbClock #(
  parameter int PERIOD_NS = 20
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  // toggle every half period
  always #(PERIOD_NS / 2) clk = ~clk;

endmodule

//--- src/mipsCore.sv
/*
 * single-cycle MIPS core
 * fetch, decode, execute, memory and write-back in one clock
 * instruction and data memories sit outside on plain ports
 */

`timescale 1ns/1ps

`include "mips_defines.svh"

module mipsCore (
  input  logic                       clk,
  input  logic                       rst,
  // instruction fetch
  output logic [`XLEN-1:0]           instrAddr,
  input  logic [`XLEN-1:0]           instr,
  // data memory
  output logic [`DMEM_ADDR_BITS-1:0] dmemAddr,
  output logic [`XLEN-1:0]           dmemWdata,
  output logic                       dmemWen,
  input  logic [`XLEN-1:0]           dmemRdata,
  // write-back observation
  output logic                       rfWrite,
  output mipsIsaPkg::regAddrT        rfWriteAddr,
  output logic [`XLEN-1:0]           rfWriteData
);

  logic [mipsIsaPkg::IMM_W-1:0]   imm;
  logic [mipsIsaPkg::JADDR_W-1:0] jumpField;
  logic [`XLEN-1:0]               immExt;
  logic [`XLEN-1:0]               aluB;
  logic [`XLEN-1:0]               aluResult;
  logic                           aluZero;
  logic [`XLEN-1:0]               pc;
  logic [`XLEN-1:0]               pcPlus4;
  mipsIsaPkg::regAddrT            destReg;
  logic [`XLEN-1:0]               wbData;

  ctrlIf    ctrlBus ();
  regFileIf rfBus ();

  // ============================================================
  // instruction fields
  // ============================================================
  assign imm       = instr[15:0];
  assign jumpField = instr[25:0];
  assign immExt    = {{(`XLEN - mipsIsaPkg::IMM_W){imm[mipsIsaPkg::IMM_W-1]}}, imm};

  instrDecoder uDecoder (
    .instr (instr),
    .ctrl  (ctrlBus)
  );

  // rs and rt straight from the word
  assign rfBus.rdAddr1 = instr[25:21];
  assign rfBus.rdAddr2 = instr[20:16];

  regFile uRegFile (
    .clk (clk),
    .rst (rst),
    .rf  (rfBus)
  );

  // immediate for lw/sw offsets
  assign aluB = ctrlBus.aluSrc ? immExt : rfBus.rdData2;

  aluUnit uAlu (
    .opA     (rfBus.rdData1),
    .opB     (aluB),
    .aluFunc (ctrlBus.aluFunc),
    .result  (aluResult),
    .zero    (aluZero)
  );

  pcUnit uPc (
    .clk        (clk),
    .rst        (rst),
    .ctrl       (ctrlBus),
    .zero       (aluZero),
    .immExt     (immExt),
    .jumpTarget (jumpField),
    .pc         (pc),
    .pcPlus4    (pcPlus4)
  );

  // ============================================================
  // write-back select
  // ============================================================
  // r31 for jal, rd for R-type, rt otherwise
  assign destReg = ctrlBus.link   ? mipsIsaPkg::LINK_REG :
                   ctrlBus.regDst ? mipsIsaPkg::regAddrT'(instr[15:11]) :
                                    mipsIsaPkg::regAddrT'(instr[20:16]);

  assign wbData = ctrlBus.link     ? pcPlus4   :
                  ctrlBus.memToReg ? dmemRdata :
                                     aluResult;

  assign rfBus.wrAddr = destReg;
  assign rfBus.wrData = wbData;
  assign rfBus.wrEn   = ctrlBus.regWrite;

  // memory and observation ports
  assign instrAddr   = pc;
  assign dmemAddr    = aluResult[`DMEM_ADDR_BITS+1:2];
  assign dmemWdata   = rfBus.rdData2;
  // active-low strobe
  assign dmemWen     = ~ctrlBus.memWrite;
  assign rfWrite     = ctrlBus.regWrite;
  assign rfWriteAddr = destReg;
  assign rfWriteData = wbData;

endmodule

//--- src/pcUnit.sv
/*
 * program counter
 * PC register with sequential, branch and jump next-address selection
 */

`timescale 1ns/1ps

`include "mips_defines.svh"

module pcUnit (
  input  logic                               clk,
  input  logic                               rst,
  ctrlIf.dst                                 ctrl,
  input  logic                               zero,
  input  logic [`XLEN-1:0]                   immExt,
  input  logic [mipsIsaPkg::JADDR_W-1:0]     jumpTarget,
  output logic [`XLEN-1:0]                   pc,
  output logic [`XLEN-1:0]                   pcPlus4
);

  logic [`XLEN-1:0] branchAddr;
  logic [`XLEN-1:0] jumpAddr;
  logic [`XLEN-1:0] pcNext;

  assign pcPlus4    = pc + `XLEN'd4;
  // word offset from the delay-free next pc
  assign branchAddr = pcPlus4 + {immExt[`XLEN-3:0], 2'b00};
  // region bits kept from pc + 4
  assign jumpAddr   = {pcPlus4[`XLEN-1 -: 4], jumpTarget, 2'b00};

  // ============================================================
  // next-address select, jump before branch
  // ============================================================
  always_comb begin
    if (ctrl.jump) begin
      pcNext = jumpAddr;
    end else if (ctrl.branch && zero) begin
      pcNext = branchAddr;
    end else begin
      pcNext = pcPlus4;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= `RESET_PC;
    end else begin
      pc <= pcNext;
    end
  end

endmodule

//--- src/aluUnit.sv
/*
 * 32-bit ALU
 * add, sub, and, or and unsigned set-less-than with a zero flag
 */

`timescale 1ns/1ps

`include "mips_defines.svh"

module aluUnit (
  input  logic [`XLEN-1:0]     opA,
  input  logic [`XLEN-1:0]     opB,
  input  mipsCtrlPkg::aluFuncE aluFunc,
  output logic [`XLEN-1:0]     result,
  output logic                 zero
);

  always_comb begin
    case (aluFunc)
      mipsCtrlPkg::ALU_ADD: result = opA + opB;
      mipsCtrlPkg::ALU_SUB: result = opA - opB;
      mipsCtrlPkg::ALU_AND: result = opA & opB;
      mipsCtrlPkg::ALU_OR:  result = opA | opB;
      // unsigned compare
      mipsCtrlPkg::ALU_SLT: result = {{(`XLEN-1){1'b0}}, (opA < opB)};
      // none and anything else
      default:              result = '0;
    endcase
  end

  // beq equality test via sub
  assign zero = (result == '0);

endmodule

//--- src/regFile.sv
/*
 * register file
 * 32 words, two async read ports, one clocked write port, r0 tied to zero
 */

`timescale 1ns/1ps

`include "mips_defines.svh"

module regFile (
  input  logic   clk,
  input  logic   rst,
  regFileIf.owner rf
);

  logic [`XLEN-1:0] regs [`REG_COUNT];

  // ============================================================
  // write port
  // ============================================================
  // whole array cleared while in reset
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (rf.wrEn && (rf.wrAddr != '0)) begin
      // writes to r0 dropped
      regs[rf.wrAddr] <= rf.wrData;
    end
  end

  // ============================================================
  // read ports
  // ============================================================
  // r0 forced to zero on both ports
  assign rf.rdData1 = (rf.rdAddr1 == '0) ? '0 : regs[rf.rdAddr1];
  assign rf.rdData2 = (rf.rdAddr2 == '0) ? '0 : regs[rf.rdAddr2];

endmodule

//--- src/instrDecoder.sv
/*
 * instruction decoder
 * opcode and function field into the control bundle and ALU function
 */

`timescale 1ns/1ps

`include "mips_defines.svh"

module instrDecoder (
  input  logic [`XLEN-1:0] instr,
  ctrlIf.src               ctrl
);

  mipsIsaPkg::opcodeE   opcode;
  mipsIsaPkg::functE    funct;
  mipsCtrlPkg::aluOpE   aluOp;
  mipsCtrlPkg::aluFuncE aluFunc;
  logic regDst, aluSrc, memToReg, regWrite;
  logic memWrite, branch, jump, link;
  logic badFunct;

  assign opcode = mipsIsaPkg::opcodeE'(instr[31:26]);
  assign funct  = mipsIsaPkg::functE'(instr[5:0]);

  // ============================================================
  // main control from the opcode
  // ============================================================
  always_comb begin
    regDst   = 1'b0;
    aluSrc   = 1'b0;
    memToReg = 1'b0;
    regWrite = 1'b0;
    memWrite = 1'b0;
    branch   = 1'b0;
    jump     = 1'b0;
    link     = 1'b0;
    aluOp    = mipsCtrlPkg::ALUOP_MEM;
    case (opcode)
      mipsIsaPkg::OP_RTYPE: begin
        regDst   = 1'b1;
        regWrite = 1'b1;
        aluOp    = mipsCtrlPkg::ALUOP_RTYPE;
      end
      mipsIsaPkg::OP_LW: begin
        aluSrc   = 1'b1;
        memToReg = 1'b1;
        regWrite = 1'b1;
      end
      mipsIsaPkg::OP_SW: begin
        aluSrc   = 1'b1;
        memWrite = 1'b1;
      end
      mipsIsaPkg::OP_BEQ: begin
        branch = 1'b1;
        aluOp  = mipsCtrlPkg::ALUOP_CMP;
      end
      mipsIsaPkg::OP_J: jump = 1'b1;
      mipsIsaPkg::OP_JAL: begin
        jump     = 1'b1;
        link     = 1'b1;
        regWrite = 1'b1;
      end
      // unknown opcode, all strobes stay low
      default: ;
    endcase
  end

  // ALU control, class first then funct for R-type
  always_comb begin
    case (aluOp)
      mipsCtrlPkg::ALUOP_MEM: aluFunc = mipsCtrlPkg::ALU_ADD;
      mipsCtrlPkg::ALUOP_CMP: aluFunc = mipsCtrlPkg::ALU_SUB;
      default: begin
        case (funct)
          mipsIsaPkg::FN_ADD: aluFunc = mipsCtrlPkg::ALU_ADD;
          mipsIsaPkg::FN_SUB: aluFunc = mipsCtrlPkg::ALU_SUB;
          mipsIsaPkg::FN_AND: aluFunc = mipsCtrlPkg::ALU_AND;
          mipsIsaPkg::FN_OR:  aluFunc = mipsCtrlPkg::ALU_OR;
          mipsIsaPkg::FN_SLT: aluFunc = mipsCtrlPkg::ALU_SLT;
          default:            aluFunc = mipsCtrlPkg::ALU_NONE;
        endcase
      end
    endcase
  end

  // unknown funct under R-type becomes a nop
  assign badFunct = (aluOp == mipsCtrlPkg::ALUOP_RTYPE) &&
                    (aluFunc == mipsCtrlPkg::ALU_NONE);

  assign ctrl.regDst   = regDst;
  assign ctrl.aluSrc   = aluSrc;
  assign ctrl.memToReg = memToReg;
  assign ctrl.regWrite = regWrite & ~badFunct;
  assign ctrl.memWrite = memWrite;
  assign ctrl.branch   = branch;
  assign ctrl.jump     = jump;
  assign ctrl.link     = link;
  assign ctrl.aluFunc  = aluFunc;

endmodule

//--- src/mipsIfaces.sv
/*
 * MIPS core internal bundles
 * control bundle from the decoder and the register-file access port
 */

`timescale 1ns/1ps

`include "mips_defines.svh"

// ============================================================
// decoder control bundle
// ============================================================
interface ctrlIf;
  // write-back destination is rd
  logic regDst;
  // second ALU operand is the immediate
  logic aluSrc;
  logic memToReg;
  logic regWrite;
  logic memWrite;
  logic branch;
  logic jump;
  // jal: write pc + 4 to r31
  logic link;
  mipsCtrlPkg::aluFuncE aluFunc;

  modport src (output regDst, aluSrc, memToReg, regWrite, memWrite,
               branch, jump, link, aluFunc);
  modport dst (input regDst, aluSrc, memToReg, regWrite, memWrite,
               branch, jump, link, aluFunc);
endinterface

// ============================================================
// register-file access
// ============================================================
interface regFileIf;
  mipsIsaPkg::regAddrT rdAddr1;
  mipsIsaPkg::regAddrT rdAddr2;
  mipsIsaPkg::regAddrT wrAddr;
  logic [`XLEN-1:0]    wrData;
  logic                wrEn;
  // async read data
  logic [`XLEN-1:0]    rdData1;
  logic [`XLEN-1:0]    rdData2;

  // the storage side
  modport owner (input rdAddr1, rdAddr2, wrAddr, wrData, wrEn,
                 output rdData1, rdData2);
  // the datapath side
  modport user (output rdAddr1, rdAddr2, wrAddr, wrData, wrEn,
                input rdData1, rdData2);
endinterface

//--- src/mipsCtrlPkg.sv
/*
 * MIPS internal control types
 * ALU operation class from the decoder and the ALU function select
 */

package mipsCtrlPkg;

  // operation class, picked from the opcode alone
  typedef enum logic [1:0] {
    ALUOP_MEM   = 2'b00,
    ALUOP_CMP   = 2'b01,
    ALUOP_RTYPE = 2'b10
  } aluOpE;

  // ============================================================
  // ALU function select
  // ============================================================
  // encodings follow the classic MIPS ALU control lines
  typedef enum logic [3:0] {
    ALU_AND  = 4'b0000,
    ALU_OR   = 4'b0001,
    ALU_ADD  = 4'b0010,
    ALU_SUB  = 4'b0110,
    ALU_SLT  = 4'b0111,
    // result forced to zero
    ALU_NONE = 4'b1111
  } aluFuncE;

endpackage

//--- src/mipsIsaPkg.sv
/*
 * MIPS instruction-set types
 * opcode and function encodings, field widths and register index type
 */

package mipsIsaPkg;

  // ============================================================
  // instruction field widths
  // ============================================================
  localparam int OPCODE_W   = 6;
  localparam int FUNCT_W    = 6;
  localparam int REG_ADDR_W = 5;
  localparam int IMM_W      = 16;
  localparam int JADDR_W    = 26;

  // register index
  typedef logic [REG_ADDR_W-1:0] regAddrT;

  // jal return address register
  localparam regAddrT LINK_REG = 5'd31;

  // primary opcodes of the supported subset
  typedef enum logic [OPCODE_W-1:0] {
    OP_RTYPE = 6'b000000,
    OP_J     = 6'b000010,
    OP_JAL   = 6'b000011,
    OP_BEQ   = 6'b000100,
    OP_LW    = 6'b100011,
    OP_SW    = 6'b101011
  } opcodeE;

  // function codes under the R-type opcode
  typedef enum logic [FUNCT_W-1:0] {
    FN_ADD = 6'b100000,
    FN_SUB = 6'b100010,
    FN_AND = 6'b100100,
    FN_OR  = 6'b100101,
    FN_SLT = 6'b101010
  } functE;

endpackage

//--- src/mips_defines.svh
/*
 * MIPS core global parameters
 * data width, register count, data-memory word address and reset fetch address
 */

`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// ============================================================
// datapath sizing
// ============================================================

// data and address width
`define XLEN 32

// architectural registers
`define REG_COUNT 32

// ============================================================
// memory map
// ============================================================

// 128-word data memory, word addressed
`define DMEM_ADDR_BITS 7

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif
